// File: vlog.f
+incdir+src
src/histEqPkg.sv
src/histBinMemory.sv
src/histogramCounter.sv
src/cdfFetch.sv
src/cdfAccumulator.sv
src/pixelMapper.sv
src/histEqSequencer.sv
src/histEqTop.sv
verification/tb_histEq.sv

// File: Makefile
# Verilator flow for the histogram-equalization engine

TOP = tb_histEq

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module histEqTop
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_histEq.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module tb_histEq;

  localparam int FRAME_PIXELS = 1 << `HIST_FRAME_LOG2;
  localparam int CLEAR_WAIT = 260;
  localparam int READY_LIMIT = 300;
  // one frame: clear wait, pixels, fetch, a full sweep of grey levels and some slack
  localparam int FRAME_CYCLES = CLEAR_WAIT + FRAME_PIXELS + READY_LIMIT + `HIST_BINS + 20;
  localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + 500;

  logic       clock;
  logic       reset_n;
  logic       frameStart;
  logic       frameEnd;
  logic       pixelValid;
  logic [7:0] pixel;
  logic       busy;
  logic       ready;
  logic       mappedValid;
  logic [7:0] mappedPixel;

  logic [7:0]  framePixels [0:FRAME_PIXELS-1];
  logic [7:0]  expectedLevel [0:`HIST_BINS-1];
  logic [7:0]  lookupExpected;
  logic [7:0]  expectedPixel;
  logic [31:0] randomState;
  int          errorCount;
  int          handshakeErrors;
  int          failedTests;
  int          testsRun;

  histEqTop histEqTop_inst (
    .clock       (clock),
    .reset_n     (reset_n),
    .frameStart  (frameStart),
    .frameEnd    (frameEnd),
    .pixelValid  (pixelValid),
    .pixel       (pixel),
    .busy        (busy),
    .ready       (ready),
    .mappedValid (mappedValid),
    .mappedPixel (mappedPixel)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // model level of the pixel on the bus, delayed to line up with mappedPixel
  assign lookupExpected = expectedLevel[pixel];

  always @(posedge clock)
    expectedPixel <= lookupExpected;

  mapLatency: assert property (@(posedge clock) disable iff (!reset_n)
    (ready && pixelValid) |=> mappedValid)
  else
  begin
    errorCount++;
    $display("%0t: a mapping-phase pixel got no mappedValid one cycle later", $time);
  end

  spuriousValid: assert property (@(posedge clock) disable iff (!reset_n)
    !(ready && pixelValid) |=> !mappedValid)
  else
  begin
    errorCount++;
    $display("%0t: mappedValid rose without a mapping-phase pixel before it", $time);
  end

  mapValue: assert property (@(posedge clock) disable iff (!reset_n)
    mappedValid |-> (mappedPixel == expectedPixel))
  else
  begin
    errorCount++;
    $display("ERR %0t mappedPixel expected %0d actual %0d", $time,
             $sampled(expectedPixel), $sampled(mappedPixel));
  end

  readyBusyExclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(ready && busy))
  else
  begin
    errorCount++;
    handshakeErrors++;
    $display("%0t: ready and busy are high together", $time);
  end

  busyRise: assert property (@(posedge clock) disable iff (!reset_n)
    frameStart |=> busy)
  else
  begin
    errorCount++;
    handshakeErrors++;
    $display("%0t: busy did not rise the cycle after frameStart", $time);
  end

  busyHold: assert property (@(posedge clock) disable iff (!reset_n)
    busy |=> (busy || ready))
  else
  begin
    errorCount++;
    handshakeErrors++;
    $display("%0t: busy dropped before ready rose", $time);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic nextCycle();
    @(posedge clock);
    #2; // all stimulus lands just after the edge
  endtask

  task automatic expectLow(input string name, input logic value);
    assert (value === 1'b0)
    else
    begin
      errorCount++;
      $display("ERR %0t %s expected 0 actual %b", $time, name, value);
    end
  endtask

  task automatic fillRandomFrame();
    for (int i = 0; i < FRAME_PIXELS; i++)
    begin
      randomState = xorshift32(randomState);
      framePixels[i] = randomState[15:8];
    end
  endtask

  task automatic fillFlatFrame(input logic [7:0] grey);
    for (int i = 0; i < FRAME_PIXELS; i++)
      framePixels[i] = grey;
  endtask

  // cumulative count times 255, shifted down by the frame size
  task automatic buildModel();
    int histogram [0:`HIST_BINS-1];
    int cumulative;
    for (int v = 0; v < `HIST_BINS; v++)
      histogram[v] = 0;
    for (int i = 0; i < FRAME_PIXELS; i++)
      histogram[framePixels[i]]++;
    cumulative = 0;
    for (int v = 0; v < `HIST_BINS; v++)
    begin
      cumulative += histogram[v];
      expectedLevel[v] = 8'((cumulative * 255) >> `HIST_FRAME_LOG2);
    end
  endtask

  task automatic startFrame();
    frameStart = 1'b1;
    nextCycle();
    frameStart = 1'b0;
    assert (busy === 1'b1)
    else
    begin
      errorCount++;
      handshakeErrors++;
      $display("%0t: the engine did not report busy after frameStart", $time);
    end
    repeat (CLEAR_WAIT) nextCycle(); // the bin clear has to finish first
  endtask

  task automatic streamFrame();
    for (int i = 0; i < FRAME_PIXELS; i++)
    begin
      pixelValid = 1'b1;
      pixel      = framePixels[i];
      nextCycle();
    end
    pixelValid = 1'b0;
    frameEnd   = 1'b1;
    nextCycle();
    frameEnd = 1'b0;
  endtask

  task automatic waitForReady();
    int cycles;
    cycles = 0;
    while (!ready && cycles < READY_LIMIT)
    begin
      nextCycle();
      cycles++;
    end
    assert (ready === 1'b1)
    else
    begin
      errorCount++;
      handshakeErrors++;
      $display("%0t: ready did not rise within %0d cycles of frameEnd", $time, READY_LIMIT);
    end
  endtask

  task automatic mapAllLevels();
    for (int v = 0; v < `HIST_BINS; v++)
    begin
      pixelValid = 1'b1;
      pixel      = v[7:0];
      nextCycle();
    end
    pixelValid = 1'b0;
    nextCycle();
    nextCycle(); // let the last answer be checked
  endtask

  task automatic reportTest(input int number, input string name, input int errors);
    testsRun++;
    if (errors != 0)
      failedTests++;
    $display("test %0d %s: %s (%0d errors)", number, name, (errors == 0) ? "ok" : "FAILED",
             errors);
  endtask

  task automatic runFrame();
    buildModel();
    startFrame();
    streamFrame();
    waitForReady();
    mapAllLevels();
  endtask

  initial
  begin
    int errorsBefore;
    reset_n         = 1'b0;
    frameStart      = 1'b0;
    frameEnd        = 1'b0;
    pixelValid      = 1'b0;
    pixel           = 8'd0;
    randomState     = 32'he1e94c1f;
    errorCount      = 0;
    handshakeErrors = 0;
    failedTests     = 0;
    testsRun        = 0;
    for (int v = 0; v < `HIST_BINS; v++)
      expectedLevel[v] = 8'd0;

    repeat (3) nextCycle();
    reset_n = 1'b1;
    nextCycle();

    errorsBefore = errorCount;
    expectLow("busy", busy);
    expectLow("ready", ready);
    expectLow("mappedValid", mappedValid);
    reportTest(1, "reset state", errorCount - errorsBefore);

    errorsBefore = errorCount;
    fillRandomFrame();
    runFrame();
    reportTest(2, "random frame", errorCount - errorsBefore);

    // every pixel in one bin, which also chains the read-modify-write back to back
    errorsBefore = errorCount;
    fillFlatFrame(8'd100);
    runFrame();
    reportTest(3, "single grey frame", errorCount - errorsBefore);

    errorsBefore = errorCount;
    fillRandomFrame();
    runFrame();
    reportTest(4, "second random frame", errorCount - errorsBefore);

    reportTest(5, "busy and ready handshake", handshakeErrors);

    $display("summary: %0d tests run, %0d failed, %0d errors", testsRun, failedTests,
             errorCount);
    if (errorCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/histEqTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module histEqTop (
  input  wire logic       clock,
  input  wire logic       reset_n,
  input  wire logic       frameStart,
  input  wire logic       frameEnd,
  input  wire logic       pixelValid,
  input  wire logic [7:0] pixel,
  output logic            busy,
  output logic            ready,
  output logic            mappedValid,
  output logic      [7:0] mappedPixel
);

  import histEqPkg::*;

  logic                         clearBins;
  logic                         fetchStart;
  logic                         fetchDone;
  logic                         bank;

  logic [`HIST_ADDR_WIDTH-1:0]  countReadAddr;
  logic [`HIST_ADDR_WIDTH-1:0]  fetchReadAddr;
  logic [`HIST_ADDR_WIDTH-1:0]  mapReadAddr;
  histWord                      countReadData;
  histWord                      fetchReadData;
  histWord                      mapReadData;

  logic                         countWrite;
  logic [`HIST_ADDR_WIDTH-1:0]  countWriteAddr;
  histWord                      countWriteData;
  logic                         mapWrite;
  logic [`HIST_ADDR_WIDTH-1:0]  mapWriteAddr;
  histWord                      mapWriteData;

  logic [`HIST_COUNT_WIDTH-1:0] countOut;
  logic                         countValid;
  logic [`HIST_ADDR_WIDTH-1:0]  storeAddress;

  histEqSequencer histEqSequencer_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .frameStart (frameStart),
    .frameEnd   (frameEnd),
    .fetchDone  (fetchDone),
    .clearBins  (clearBins),
    .fetchStart (fetchStart),
    .bank       (bank),
    .busy       (busy),
    .ready      (ready)
  );

  histBinMemory histBinMemory_inst (
    .clock          (clock),
    .countReadAddr  (countReadAddr),
    .fetchReadAddr  (fetchReadAddr),
    .mapReadAddr    (mapReadAddr),
    .countReadData  (countReadData),
    .fetchReadData  (fetchReadData),
    .mapReadData    (mapReadData),
    .countWrite     (countWrite),
    .countWriteAddr (countWriteAddr),
    .countWriteData (countWriteData),
    .mapWrite       (mapWrite),
    .mapWriteAddr   (mapWriteAddr),
    .mapWriteData   (mapWriteData)
  );

  histogramCounter histogramCounter_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .clearBins  (clearBins),
    .pixelValid (pixelValid),
    .pixel      (pixel),
    .bank       (bank),
    .readAddr   (countReadAddr),
    .readData   (countReadData),
    .write      (countWrite),
    .writeAddr  (countWriteAddr),
    .writeData  (countWriteData)
  );

  cdfFetch cdfFetch_inst (
    .clock        (clock),
    .reset_n      (reset_n),
    .start        (fetchStart),
    .baseBank     (bank),
    .readBus      (fetchReadData),
    .readAddr     (fetchReadAddr),
    .countOut     (countOut),
    .countValid   (countValid),
    .storeAddress (storeAddress),
    .done         (fetchDone)
  );

  cdfAccumulator cdfAccumulator_inst (
    .clock        (clock),
    .reset_n      (reset_n),
    .countOut     (countOut),
    .countValid   (countValid),
    .storeAddress (storeAddress),
    .write        (mapWrite),
    .writeAddr    (mapWriteAddr),
    .writeData    (mapWriteData)
  );

  pixelMapper pixelMapper_inst (
    .clock       (clock),
    .reset_n     (reset_n),
    .ready       (ready),
    .pixelValid  (pixelValid),
    .bank        (bank),
    .pixel       (pixel),
    .readAddr    (mapReadAddr),
    .readData    (mapReadData),
    .mappedValid (mappedValid),
    .mappedPixel (mappedPixel)
  );

endmodule

`default_nettype wire

// File: src/histEqSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module histEqSequencer (
  input  wire logic clock,
  input  wire logic reset_n,
  input  wire logic frameStart,
  input  wire logic frameEnd,
  input  wire logic fetchDone,
  output logic      clearBins,
  output logic      fetchStart,
  output logic      bank,
  output logic      busy,
  output logic      ready
);

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] COUNT = 2'd1; // clearing runs at the start of this phase
  localparam logic [1:0] FETCH = 2'd2;
  localparam logic [1:0] READY = 2'd3;

  logic [1:0] phase;

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      phase     <= IDLE;
      bank      <= 1'b0;
      clearBins <= 1'b0;
    end
    else
    begin
      clearBins <= 1'b0;
      case (phase)
        IDLE, READY:
          if (frameStart)
          begin
            phase     <= COUNT;
            bank      <= ~bank; // each frame works in the other bank
            clearBins <= 1'b1;
          end
        COUNT:
          if (frameEnd)
            phase <= FETCH;
        FETCH:
          if (fetchDone)
            phase <= READY;
        default:
          phase <= IDLE;
      endcase
    end
  end

  assign busy       = (phase == COUNT) || (phase == FETCH);
  assign fetchStart = (phase == FETCH);
  assign ready      = (phase == READY);

endmodule

`default_nettype wire

// File: src/pixelMapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module pixelMapper (
  input  wire logic                        clock,
  input  wire logic                        reset_n,
  input  wire logic                        ready,
  input  wire logic                        pixelValid,
  input  wire logic                        bank,
  input  wire logic [7:0]                  pixel,
  output logic      [`HIST_ADDR_WIDTH-1:0] readAddr,
  input  histEqPkg::histWord               readData,
  output logic                             mappedValid,
  output logic      [7:0]                  mappedPixel
);

  logic [7:0] lookupLevel;

  assign readAddr = {bank, {(`HIST_ADDR_WIDTH-9){1'b0}}, pixel};

  always_comb
  begin
    if (readData.mapView.tag == `HIST_MAP_TAG)
      lookupLevel = readData.mapView.level;
    else
      lookupLevel = 8'd0; // slot never received a level
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
      mappedValid <= 1'b0;
    else
      mappedValid <= ready & pixelValid;
  end

  always_ff @(posedge clock)
  begin
    if (ready && pixelValid)
      mappedPixel <= lookupLevel;
  end

endmodule

`default_nettype wire

// File: src/cdfAccumulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module cdfAccumulator (
  input  wire logic                         clock,
  input  wire logic                         reset_n,
  input  wire logic [`HIST_COUNT_WIDTH-1:0] countOut,
  input  wire logic                         countValid,
  input  wire logic [`HIST_ADDR_WIDTH-1:0]  storeAddress,
  output logic                              write,
  output logic      [`HIST_ADDR_WIDTH-1:0]  writeAddr,
  output histEqPkg::histWord                writeData
);

  logic [`HIST_COUNT_WIDTH-1:0]   runningSum;
  logic [`HIST_COUNT_WIDTH-1:0]   newSum;
  logic [`HIST_COUNT_WIDTH+7:0]   scaledSum;

  assign newSum = runningSum + countOut;

  // a full frame scales to 255, so the level fits in 8 bits after the shift
  assign scaledSum = newSum * 8'd255;

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
      runningSum <= '0;
    else if (countValid)
      runningSum <= newSum;
    else
      runningSum <= '0; // ready for the next frame
  end

  always_comb
  begin
    write                      = countValid;
    writeAddr                  = storeAddress;
    writeData.mapView.tag      = `HIST_MAP_TAG;
    writeData.mapView.reserved = '0;
    writeData.mapView.level    = scaledSum[`HIST_FRAME_LOG2+7:`HIST_FRAME_LOG2];
  end

endmodule

`default_nettype wire

// File: src/cdfFetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module cdfFetch (
  input  wire logic                        clock,
  input  wire logic                        reset_n,
  input  wire logic                        start,
  input  wire logic                        baseBank,
  input  histEqPkg::histWord               readBus,
  output logic      [`HIST_ADDR_WIDTH-1:0] readAddr,
  output logic      [`HIST_COUNT_WIDTH-1:0] countOut,
  output logic                             countValid,
  output logic      [`HIST_ADDR_WIDTH-1:0] storeAddress,
  output logic                             done
);

  logic [8:0]                   binCount;
  logic [`HIST_COUNT_WIDTH-1:0] taggedCount;
  logic                         done0;
  logic                         done1;

  // anything that is not a bin entry contributes nothing to the sum
  always_comb
  begin
    if (readBus.binView.tag == `HIST_BIN_TAG)
      taggedCount = readBus.binView.count;
    else
      taggedCount = '0;
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      storeAddress <= '0;
      done1        <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      storeAddress <= readAddr; // the slot that countOut was read from
      done1        <= done0;
      done         <= done1;
    end
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      readAddr   <= '0;
      countOut   <= '0;
      countValid <= 1'b0;
      binCount   <= '0;
      done0      <= 1'b0;
    end
    else if (start && binCount < 9'(`HIST_BINS))
    begin
      readAddr   <= readAddr + 1'b1;
      countOut   <= taggedCount;
      countValid <= 1'b1;
      binCount   <= binCount + 1'b1;
      done0      <= 1'b0;
    end
    else if (start)
    begin
      countOut   <= '0; // walk finished, hold here until start drops
      countValid <= 1'b0;
      done0      <= 1'b1;
    end
    else
    begin
      readAddr   <= {baseBank, {(`HIST_ADDR_WIDTH-1){1'b0}}};
      countOut   <= '0;
      countValid <= 1'b0;
      binCount   <= '0;
      done0      <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/histogramCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module histogramCounter (
  input  wire logic                        clock,
  input  wire logic                        reset_n,
  input  wire logic                        clearBins,
  input  wire logic                        pixelValid,
  input  wire logic [7:0]                  pixel,
  input  wire logic                        bank,
  output logic      [`HIST_ADDR_WIDTH-1:0] readAddr,
  input  histEqPkg::histWord               readData,
  output logic                             write,
  output logic      [`HIST_ADDR_WIDTH-1:0] writeAddr,
  output histEqPkg::histWord               writeData
);

  logic                        clearing;
  logic                        counting;
  logic [7:0]                  clearIndex;
  logic [`HIST_FRAME_LOG2-1:0] pixelCount;
  logic                        countPixel;

  assign countPixel = counting & pixelValid;

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      clearing   <= 1'b0;
      counting   <= 1'b0;
      clearIndex <= '0;
      pixelCount <= '0;
    end
    else if (clearBins)
    begin
      clearing   <= 1'b1;
      counting   <= 1'b0;
      clearIndex <= '0;
    end
    else if (clearing)
    begin
      clearIndex <= clearIndex + 1'b1;
      if (clearIndex == 8'(`HIST_BINS - 1))
      begin
        clearing   <= 1'b0; // last bin written, counting starts next cycle
        counting   <= 1'b1;
        pixelCount <= '0;
      end
    end
    else if (countPixel)
    begin
      pixelCount <= pixelCount + 1'b1;
      if (&pixelCount)
        counting <= 1'b0; // frame complete, later pixels belong to mapping
    end
  end

  assign readAddr = {bank, {(`HIST_ADDR_WIDTH-9){1'b0}}, pixel};

  // read-modify-write in one cycle so repeated pixels chain correctly
  always_comb
  begin
    write                    = clearing | countPixel;
    writeData.binView.tag    = `HIST_BIN_TAG;
    if (clearing)
    begin
      writeAddr               = {bank, {(`HIST_ADDR_WIDTH-9){1'b0}}, clearIndex};
      writeData.binView.count = '0;
    end
    else
    begin
      writeAddr               = readAddr;
      writeData.binView.count = readData.binView.count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/histBinMemory.sv
`timescale 1ns/10ps
`default_nettype none

`include "histEq_defines.svh"

module histBinMemory (
  input  wire logic                        clock,
  input  wire logic [`HIST_ADDR_WIDTH-1:0] countReadAddr,
  input  wire logic [`HIST_ADDR_WIDTH-1:0] fetchReadAddr,
  input  wire logic [`HIST_ADDR_WIDTH-1:0] mapReadAddr,
  output histEqPkg::histWord               countReadData,
  output histEqPkg::histWord               fetchReadData,
  output histEqPkg::histWord               mapReadData,
  input  wire logic                        countWrite,
  input  wire logic [`HIST_ADDR_WIDTH-1:0] countWriteAddr,
  input  histEqPkg::histWord               countWriteData,
  input  wire logic                        mapWrite,
  input  wire logic [`HIST_ADDR_WIDTH-1:0] mapWriteAddr,
  input  histEqPkg::histWord               mapWriteData
);

  import histEqPkg::*;

  histWord storage [0:2*`HIST_BINS-1];

  logic [8:0] countReadIndex;
  logic [8:0] fetchReadIndex;
  logic [8:0] mapReadIndex;
  logic [8:0] countWriteIndex;
  logic [8:0] mapWriteIndex;

  // bank bit on top of the bin number, address bits 14:8 are not decoded
  assign countReadIndex  = {countReadAddr[`HIST_ADDR_WIDTH-1], countReadAddr[7:0]};
  assign fetchReadIndex  = {fetchReadAddr[`HIST_ADDR_WIDTH-1], fetchReadAddr[7:0]};
  assign mapReadIndex    = {mapReadAddr[`HIST_ADDR_WIDTH-1], mapReadAddr[7:0]};
  assign countWriteIndex = {countWriteAddr[`HIST_ADDR_WIDTH-1], countWriteAddr[7:0]};
  assign mapWriteIndex   = {mapWriteAddr[`HIST_ADDR_WIDTH-1], mapWriteAddr[7:0]};

  assign countReadData = storage[countReadIndex];
  assign fetchReadData = storage[fetchReadIndex];
  assign mapReadData   = storage[mapReadIndex];

  // the two writers belong to different phases and are never active together
  always_ff @(posedge clock)
  begin
    if (countWrite)
      storage[countWriteIndex] <= countWriteData;
    if (mapWrite)
      storage[mapWriteIndex] <= mapWriteData;
  end

endmodule

`default_nettype wire

// File: src/histEqPkg.sv
`default_nettype none

`include "histEq_defines.svh"

package histEqPkg;

  // one memory word, seen as a histogram bin or as a map entry
  typedef union packed {
    struct packed {
      logic [15:0]                  tag;
      logic [`HIST_COUNT_WIDTH-1:0] count;
    } binView;
    struct packed {
      logic [15:0]                    tag;
      logic [`HIST_COUNT_WIDTH-9:0]   reserved;
      logic [7:0]                     level;
    } mapView;
  } histWord;

endpackage

`default_nettype wire

// File: src/histEq_defines.svh
`ifndef HIST_EQ_DEFINES_SVH
`define HIST_EQ_DEFINES_SVH

// grey levels, and so bins per bank
`define HIST_BINS 256

// a frame holds 1 << HIST_FRAME_LOG2 pixels
`define HIST_FRAME_LOG2 10

`define HIST_COUNT_WIDTH 20

// bit 15 picks the bank, bits 7:0 pick the bin
`define HIST_ADDR_WIDTH 16

// entry tags kept in the top 16 bits of a memory word
`define HIST_BIN_TAG 16'haaaa
`define HIST_MAP_TAG 16'h5555

`endif
